/* hw/iu_pkg.sv */
package iu_pkg;

  // Datapath and register file widths
  localparam int XLEN      = 32;
  localparam int PREG_W    = 6;

  // One quotient bit per iteration
  localparam int DIV_ITERS = 32;

  typedef logic [XLEN-1:0]   data_t;
  typedef logic [PREG_W-1:0] preg_t;

  // Op code from decode picks the unit on its own
  typedef enum logic [4:0] {
    FN_ADD   = 5'd0,
    FN_SUB   = 5'd1,
    FN_AND   = 5'd2,
    FN_OR    = 5'd3,
    FN_XOR   = 5'd4,
    FN_SLL   = 5'd5,
    FN_SRL   = 5'd6,
    FN_SRA   = 5'd7,
    FN_SLT   = 5'd8,
    FN_SLTU  = 5'd9,
    FN_MUL   = 5'd10,
    FN_MULH  = 5'd11,
    FN_MULHU = 5'd12,
    FN_DIV   = 5'd13,
    FN_DIVU  = 5'd14,
    FN_REM   = 5'd15,
    FN_REMU  = 5'd16
  } iu_func_e;

  // Divider FSM
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_ITER = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

endpackage

/* hw/iu_ex1_if.sv */
`timescale 1ns/10ps

interface iu_ex1_if;
  import iu_pkg::*;

  logic     inst_vld;
  iu_func_e func;
  data_t    src0;
  data_t    src1;
  preg_t    dst_preg;

  modport src (
    output inst_vld,
    output func,
    output src0,
    output src1,
    output dst_preg
  );

  modport unit (
    input inst_vld,
    input func,
    input src0,
    input src1,
    input dst_preg
  );

endinterface

/* hw/iu_alu.sv */
`timescale 1ns/10ps

module iu_alu (
  iu_ex1_if.unit         ex1,
  output logic           alu_vld,
  output iu_pkg::data_t  alu_rslt
);
  import iu_pkg::*;

  logic       alu_op;
  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign alu_op = ex1.func inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR,
                                   FN_SLL, FN_SRL, FN_SRA, FN_SLT, FN_SLTU};

  assign alu_vld = ex1.inst_vld && alu_op;

  // Only the low five bits count for shifts
  assign shamt = ex1.src1[4:0];

  assign lt_s = $signed(ex1.src0) < $signed(ex1.src1);
  assign lt_u = ex1.src0 < ex1.src1;

  always_comb begin
    case (ex1.func)
      FN_ADD: begin
        alu_rslt = ex1.src0 + ex1.src1;
      end
      FN_SUB: begin
        alu_rslt = ex1.src0 - ex1.src1;
      end
      FN_AND: begin
        alu_rslt = ex1.src0 & ex1.src1;
      end
      FN_OR: begin
        alu_rslt = ex1.src0 | ex1.src1;
      end
      FN_XOR: begin
        alu_rslt = ex1.src0 ^ ex1.src1;
      end
      FN_SLL: begin
        alu_rslt = ex1.src0 << shamt;
      end
      FN_SRL: begin
        alu_rslt = ex1.src0 >> shamt;
      end
      FN_SRA: begin
        alu_rslt = data_t'($signed(ex1.src0) >>> shamt);
      end
      FN_SLT: begin
        alu_rslt = data_t'(lt_s);
      end
      FN_SLTU: begin
        alu_rslt = data_t'(lt_u);
      end
      default: begin
        alu_rslt = '0;
      end
    endcase
  end

endmodule

/* hw/iu_mul.sv */
`timescale 1ns/10ps

module iu_mul (
  input  logic           forever_cpuclk,
  input  logic           rst,
  input  logic           flush,
  iu_ex1_if.unit         ex1,
  output logic           mul_ex2_vld,
  output iu_pkg::preg_t  mul_ex2_preg,
  output iu_pkg::data_t  mul_ex2_rslt
);
  import iu_pkg::*;

  logic                        mul_issue;
  logic                        src0_sign;
  logic                        src1_sign;
  logic signed [2*XLEN-1:0]    op0;
  logic signed [2*XLEN-1:0]    op1;
  logic signed [2*XLEN-1:0]    prod;
  data_t                       prod_sel;

  assign mul_issue = ex1.inst_vld && (ex1.func inside {FN_MUL, FN_MULH, FN_MULHU});

  // Only MULH sign-extends its operands
  assign src0_sign = (ex1.func == FN_MULH) && ex1.src0[XLEN-1];
  assign src1_sign = (ex1.func == FN_MULH) && ex1.src1[XLEN-1];

  assign op0  = {{XLEN{src0_sign}}, ex1.src0};
  assign op1  = {{XLEN{src1_sign}}, ex1.src1};
  assign prod = op0 * op1;

  assign prod_sel = (ex1.func == FN_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];

  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      mul_ex2_vld <= 1'b0;
    end else if (flush) begin
      mul_ex2_vld <= 1'b0;
    end else begin
      mul_ex2_vld <= mul_issue;
    end
  end

  // EX2 payload
  always_ff @(posedge forever_cpuclk) begin
    if (mul_issue) begin
      mul_ex2_preg <= ex1.dst_preg;
      mul_ex2_rslt <= prod_sel;
    end
  end

endmodule

/* hw/iu_div.sv */
`timescale 1ns/10ps

module iu_div (
  input  logic           forever_cpuclk,
  input  logic           rst,
  input  logic           flush,
  iu_ex1_if.unit         ex1,
  output logic           div_busy,
  output logic           div_vld,
  output iu_pkg::preg_t  div_preg,
  output iu_pkg::data_t  div_rslt
);
  import iu_pkg::*;

  typedef logic [$clog2(DIV_ITERS)-1:0] cnt_t;

  div_state_e                     state;
  cnt_t                           cnt;
  logic                           div_op;
  logic                           div_start;
  logic                           op_signed;
  logic                           op_rem;
  logic                           src0_neg;
  logic                           src1_neg;
  data_t                          src0_abs;
  data_t                          src1_abs;

  data_t                          quo;
  data_t                          rem;
  data_t                          dvsr;
  logic                           q_neg;
  logic                           r_neg;
  logic                           is_rem;

  logic [XLEN:0]                  rem_shift;
  logic                           step_ge;
  data_t                          rem_next;
  data_t                          quo_next;
  data_t                          q_fix;
  data_t                          r_fix;

  assign div_op    = ex1.func inside {FN_DIV, FN_DIVU, FN_REM, FN_REMU};
  assign div_start = ex1.inst_vld && div_op && (state == DIV_IDLE);

  assign op_signed = (ex1.func == FN_DIV) || (ex1.func == FN_REM);
  assign op_rem    = (ex1.func == FN_REM) || (ex1.func == FN_REMU);

  assign src0_neg = op_signed && ex1.src0[XLEN-1];
  assign src1_neg = op_signed && ex1.src1[XLEN-1];
  assign src0_abs = src0_neg ? -ex1.src0 : ex1.src0;
  assign src1_abs = src1_neg ? -ex1.src1 : ex1.src1;

  assign div_busy = (state == DIV_ITER) || (state == DIV_DONE);

  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      state   <= DIV_IDLE;
      cnt     <= '0;
      div_vld <= 1'b0;
    end else if (flush) begin
      state   <= DIV_IDLE;
      div_vld <= 1'b0;
    end else begin
      div_vld <= (state == DIV_DONE);
      case (state)
        DIV_IDLE: begin
          if (div_start) begin
            state <= DIV_ITER;
            cnt   <= '0;
          end
        end
        DIV_ITER: begin
          cnt <= cnt + cnt_t'(1);
          if (cnt == cnt_t'(DIV_ITERS - 1)) begin
            state <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          state <= DIV_IDLE;
        end
        default: begin
          state <= DIV_IDLE;
        end
      endcase
    end
  end

  // Restoring step shifts dividend bits out of quo into rem
  assign rem_shift = {rem, quo[XLEN-1]};
  assign step_ge   = rem_shift >= {1'b0, dvsr};
  assign rem_next  = step_ge ? (rem_shift[XLEN-1:0] - dvsr) : rem_shift[XLEN-1:0];
  assign quo_next  = {quo[XLEN-2:0], step_ge};

  // MIN / -1 gives MIN because 0x80000000 is its own magnitude
  assign q_fix = q_neg ? -quo : quo;
  assign r_fix = r_neg ? -rem : rem;

  always_ff @(posedge forever_cpuclk) begin
    if (div_start) begin
      quo      <= src0_abs;
      dvsr     <= src1_abs;
      rem      <= '0;
      // Divide by zero keeps the all-ones quotient unsigned
      q_neg    <= (src0_neg ^ src1_neg) && (ex1.src1 != '0);
      r_neg    <= src0_neg;
      is_rem   <= op_rem;
      div_preg <= ex1.dst_preg;
    end else if (state == DIV_ITER) begin
      quo <= quo_next;
      rem <= rem_next;
    end
    if (state == DIV_DONE) begin
      div_rslt <= is_rem ? r_fix : q_fix;
    end
  end

  // Decode holds off while the stall is up
  a_no_issue_busy: assert property (
    @(posedge forever_cpuclk) disable iff (rst)
    div_busy |-> !ex1.inst_vld
  );

endmodule

/* hw/iu_ctrl.sv */
`timescale 1ns/10ps

module iu_ctrl (
  input  logic           forever_cpuclk,
  input  logic           rst,
  input  logic           flush,
  input  iu_pkg::preg_t  ex1_dst_preg,
  input  logic           alu_vld,
  input  iu_pkg::data_t  alu_rslt,
  input  logic           mul_ex2_vld,
  input  iu_pkg::preg_t  mul_ex2_preg,
  input  iu_pkg::data_t  mul_ex2_rslt,
  input  logic           div_busy,
  input  logic           div_vld,
  input  iu_pkg::preg_t  div_preg,
  input  iu_pkg::data_t  div_rslt,
  output logic           ex1_stall,
  output logic           ex1_fwd_vld,
  output iu_pkg::preg_t  ex1_fwd_preg,
  output iu_pkg::data_t  ex1_fwd_data,
  output logic           wb_vld,
  output iu_pkg::preg_t  wb_preg,
  output iu_pkg::data_t  wb_data
);
  import iu_pkg::*;

  logic  alu_ex2_vld;
  preg_t alu_ex2_preg;
  data_t alu_ex2_rslt;

  // ALU result is ready in EX1
  assign ex1_fwd_vld  = alu_vld;
  assign ex1_fwd_preg = ex1_dst_preg;
  assign ex1_fwd_data = alu_rslt;

  assign ex1_stall = div_busy;

  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      alu_ex2_vld <= 1'b0;
    end else begin
      alu_ex2_vld <= alu_vld && !flush;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (alu_vld) begin
      alu_ex2_preg <= ex1_dst_preg;
      alu_ex2_rslt <= alu_rslt;
    end
  end

  // Single writeback port
  assign wb_vld = alu_ex2_vld || mul_ex2_vld || div_vld;

  always_comb begin
    wb_preg = '0;
    wb_data = '0;
    if (alu_ex2_vld) begin
      wb_preg = alu_ex2_preg;
      wb_data = alu_ex2_rslt;
    end else if (mul_ex2_vld) begin
      wb_preg = mul_ex2_preg;
      wb_data = mul_ex2_rslt;
    end else if (div_vld) begin
      wb_preg = div_preg;
      wb_data = div_rslt;
    end
  end

  a_wb_onehot: assert property (
    @(posedge forever_cpuclk) disable iff (rst)
    $onehot0({alu_ex2_vld, mul_ex2_vld, div_vld})
  );

endmodule

/* hw/iu_top.sv */
`timescale 1ns/10ps

module iu_top (
  input  logic              forever_cpuclk,
  input  logic              rst,
  input  logic              flush,
  input  logic              ex1_inst_vld,
  input  iu_pkg::iu_func_e  ex1_func,
  input  iu_pkg::data_t     ex1_src0,
  input  iu_pkg::data_t     ex1_src1,
  input  iu_pkg::preg_t     ex1_dst_preg,
  output logic              ex1_stall,
  output logic              ex1_fwd_vld,
  output iu_pkg::preg_t     ex1_fwd_preg,
  output iu_pkg::data_t     ex1_fwd_data,
  output logic              wb_vld,
  output iu_pkg::preg_t     wb_preg,
  output iu_pkg::data_t     wb_data
);
  import iu_pkg::*;

  logic  alu_vld;
  data_t alu_rslt;
  logic  mul_ex2_vld;
  preg_t mul_ex2_preg;
  data_t mul_ex2_rslt;
  logic  div_busy;
  logic  div_vld;
  preg_t div_preg;
  data_t div_rslt;

  iu_ex1_if x_iu_ex1_if ();

  // EX1 bundle from decode
  assign x_iu_ex1_if.inst_vld = ex1_inst_vld;
  assign x_iu_ex1_if.func     = ex1_func;
  assign x_iu_ex1_if.src0     = ex1_src0;
  assign x_iu_ex1_if.src1     = ex1_src1;
  assign x_iu_ex1_if.dst_preg = ex1_dst_preg;

  iu_alu x_iu_alu (
    .ex1      (x_iu_ex1_if),
    .alu_vld  (alu_vld),
    .alu_rslt (alu_rslt)
  );

  iu_mul x_iu_mul (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .flush          (flush),
    .ex1            (x_iu_ex1_if),
    .mul_ex2_vld    (mul_ex2_vld),
    .mul_ex2_preg   (mul_ex2_preg),
    .mul_ex2_rslt   (mul_ex2_rslt)
  );

  iu_div x_iu_div (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .flush          (flush),
    .ex1            (x_iu_ex1_if),
    .div_busy       (div_busy),
    .div_vld        (div_vld),
    .div_preg       (div_preg),
    .div_rslt       (div_rslt)
  );

  iu_ctrl x_iu_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .flush          (flush),
    .ex1_dst_preg   (ex1_dst_preg),
    .alu_vld        (alu_vld),
    .alu_rslt       (alu_rslt),
    .mul_ex2_vld    (mul_ex2_vld),
    .mul_ex2_preg   (mul_ex2_preg),
    .mul_ex2_rslt   (mul_ex2_rslt),
    .div_busy       (div_busy),
    .div_vld        (div_vld),
    .div_preg       (div_preg),
    .div_rslt       (div_rslt),
    .ex1_stall      (ex1_stall),
    .ex1_fwd_vld    (ex1_fwd_vld),
    .ex1_fwd_preg   (ex1_fwd_preg),
    .ex1_fwd_data   (ex1_fwd_data),
    .wb_vld         (wb_vld),
    .wb_preg        (wb_preg),
    .wb_data        (wb_data)
  );

endmodule

/* sim/iu_tb_vectors.svh */
`ifndef IU_TB_VECTORS_SVH
`define IU_TB_VECTORS_SVH

// Columns are name, func, src0, src1, dst_preg and expected result
task automatic load_table();
  table_row("add",         FN_ADD,   32'h0000_0005, 32'h0000_0007, 6'd1,  32'h0000_000c);
  table_row("add_wrap",    FN_ADD,   32'hffff_ffff, 32'h0000_0002, 6'd2,  32'h0000_0001);
  table_row("sub",         FN_SUB,   32'h0000_0003, 32'h0000_0005, 6'd3,  32'hffff_fffe);
  table_row("and",         FN_AND,   32'hf0f0_f0f0, 32'h0ff0_0ff0, 6'd4,  32'h00f0_00f0);
  table_row("or",          FN_OR,    32'hf0f0_f0f0, 32'h0ff0_0ff0, 6'd5,  32'hfff0_fff0);
  table_row("xor",         FN_XOR,   32'hf0f0_f0f0, 32'h0ff0_0ff0, 6'd6,  32'hff00_ff00);
  // Shift amount 0x24 uses only its low five bits
  table_row("sll",         FN_SLL,   32'h0000_0001, 32'h0000_0024, 6'd7,  32'h0000_0010);
  table_row("srl",         FN_SRL,   32'h8000_0000, 32'h0000_0004, 6'd8,  32'h0800_0000);
  table_row("sra",         FN_SRA,   32'h8000_0000, 32'h0000_0004, 6'd9,  32'hf800_0000);
  table_row("slt",         FN_SLT,   32'hffff_ffff, 32'h0000_0001, 6'd10, 32'h0000_0001);
  table_row("sltu",        FN_SLTU,  32'hffff_ffff, 32'h0000_0001, 6'd11, 32'h0000_0000);
  table_row("mul",         FN_MUL,   32'hffff_fffe, 32'h0000_0003, 6'd12, 32'hffff_fffa);
  table_row("mul_mixed",   FN_MUL,   32'h0000_1234, 32'hffff_ffff, 6'd13, 32'hffff_edcc);
  table_row("mulh",        FN_MULH,  32'hffff_fffe, 32'h0000_0003, 6'd14, 32'hffff_ffff);
  table_row("mulh_min",    FN_MULH,  32'h8000_0000, 32'h8000_0000, 6'd15, 32'h4000_0000);
  table_row("mulhu",       FN_MULHU, 32'hffff_fffe, 32'h0000_0003, 6'd16, 32'h0000_0002);
  table_row("mulhu_max",   FN_MULHU, 32'hffff_ffff, 32'hffff_ffff, 6'd17, 32'hffff_fffe);
  table_row("div",         FN_DIV,   32'hffff_fff9, 32'h0000_0002, 6'd18, 32'hffff_fffd);
  table_row("rem",         FN_REM,   32'hffff_fff9, 32'h0000_0002, 6'd19, 32'hffff_ffff);
  table_row("div_pos",     FN_DIV,   32'h0000_0064, 32'h0000_0007, 6'd20, 32'h0000_000e);
  table_row("divu",        FN_DIVU,  32'hffff_fff9, 32'h0000_0002, 6'd21, 32'h7fff_fffc);
  table_row("remu",        FN_REMU,  32'hffff_fff9, 32'h0000_0002, 6'd22, 32'h0000_0001);
  table_row("div_zero",    FN_DIV,   32'hffff_fff9, 32'h0000_0000, 6'd23, 32'hffff_ffff);
  table_row("rem_zero",    FN_REM,   32'hffff_fff9, 32'h0000_0000, 6'd24, 32'hffff_fff9);
  table_row("divu_zero",   FN_DIVU,  32'h1234_5678, 32'h0000_0000, 6'd25, 32'hffff_ffff);
  table_row("remu_zero",   FN_REMU,  32'h1234_5678, 32'h0000_0000, 6'd26, 32'h1234_5678);
  // Signed overflow of the most negative number over minus one
  table_row("div_ovf",     FN_DIV,   32'h8000_0000, 32'hffff_ffff, 6'd27, 32'h8000_0000);
  table_row("rem_ovf",     FN_REM,   32'h8000_0000, 32'hffff_ffff, 6'd28, 32'h0000_0000);
endtask

`endif

/* sim/iu_tb.sv */
`timescale 1ns/10ps

module iu_tb;
  import iu_pkg::*;

  localparam int STREAM_LEN  = 200;
  localparam int WB_WAIT_MAX = DIV_ITERS + 16;

  logic     forever_cpuclk;
  logic     rst;
  logic     flush;
  logic     ex1_inst_vld;
  iu_func_e ex1_func;
  data_t    ex1_src0;
  data_t    ex1_src1;
  preg_t    ex1_dst_preg;
  logic     ex1_stall;
  logic     ex1_fwd_vld;
  preg_t    ex1_fwd_preg;
  data_t    ex1_fwd_data;
  logic     wb_vld;
  preg_t    wb_preg;
  data_t    wb_data;

  string    vec_name[$];
  iu_func_e vec_fn[$];
  data_t    vec_src0[$];
  data_t    vec_src1[$];
  preg_t    vec_dst[$];
  data_t    vec_exp[$];

  int       value_errs;
  int       proto_errs;
  int       cycle_cnt;
  int       cycle_limit;

  iu_top u_dut (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .flush          (flush),
    .ex1_inst_vld   (ex1_inst_vld),
    .ex1_func       (ex1_func),
    .ex1_src0       (ex1_src0),
    .ex1_src1       (ex1_src1),
    .ex1_dst_preg   (ex1_dst_preg),
    .ex1_stall      (ex1_stall),
    .ex1_fwd_vld    (ex1_fwd_vld),
    .ex1_fwd_preg   (ex1_fwd_preg),
    .ex1_fwd_data   (ex1_fwd_data),
    .wb_vld         (wb_vld),
    .wb_preg        (wb_preg),
    .wb_data        (wb_data)
  );

  `include "iu_tb_vectors.svh"

  initial begin
    forever_cpuclk = 1'b0;
    forever begin
      #10 forever_cpuclk = ~forever_cpuclk;
    end
  end

  initial begin
    cycle_cnt = 0;
    do begin
      @(posedge forever_cpuclk);
      cycle_cnt++;
    end while (cycle_cnt <= cycle_limit);
    $display("Error: run did not end within %0d cycles", cycle_limit);
    $display("tests failed");
    $finish;
  end

  task automatic table_row(input string name, input iu_func_e fn, input data_t a,
                           input data_t b, input preg_t dst, input data_t exp);
    vec_name.push_back(name);
    vec_fn.push_back(fn);
    vec_src0.push_back(a);
    vec_src1.push_back(b);
    vec_dst.push_back(dst);
    vec_exp.push_back(exp);
  endtask

  task automatic compare_word(input string name, input data_t exp, input data_t act);
    assert (act == exp) else begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic confirm(input logic ok, input string what);
    assert (ok) else begin
      $display("Error: %s", what);
      proto_errs++;
    end
  endtask

  task automatic drive_op(input iu_func_e fn, input data_t a, input data_t b,
                          input preg_t dst);
    ex1_inst_vld = 1'b1;
    ex1_func     = fn;
    ex1_src0     = a;
    ex1_src1     = b;
    ex1_dst_preg = dst;
  endtask

  task automatic idle_ex1();
    ex1_inst_vld = 1'b0;
    ex1_func     = FN_ADD;
    ex1_src0     = '0;
    ex1_src1     = '0;
    ex1_dst_preg = '0;
  endtask

  // Reference model on 64-bit extended operands
  function automatic data_t predict(input iu_func_e fn, input data_t a, input data_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        p;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'h0, a};
    ub = {32'h0, b};
    case (fn)
      FN_ADD:   return a + b;
      FN_SUB:   return a - b;
      FN_AND:   return a & b;
      FN_OR:    return a | b;
      FN_XOR:   return a ^ b;
      FN_SLL:   return a << b[4:0];
      FN_SRL:   return a >> b[4:0];
      FN_SRA: begin
        p = sa >>> b[4:0];
        return p[31:0];
      end
      FN_SLT:   return (sa < sb) ? 32'd1 : 32'd0;
      FN_SLTU:  return (ua < ub) ? 32'd1 : 32'd0;
      FN_MUL: begin
        p = ua * ub;
        return p[31:0];
      end
      FN_MULH: begin
        p = sa * sb;
        return p[63:32];
      end
      FN_MULHU: begin
        p = ua * ub;
        return p[63:32];
      end
      default:  return '0;
    endcase
  endfunction

  task automatic match_wb(input string name, input data_t exp, input preg_t dst);
    confirm(wb_vld, $sformatf("%s: wb_vld low where a writeback was due", name));
    compare_word(name, exp, wb_data);
    compare_word($sformatf("%s wb_preg", name), data_t'(dst), data_t'(wb_preg));
  endtask

  // Counts negedges until wb_vld and checks the stall during a divide
  task automatic await_wb(input string name, input logic is_div, output int waited);
    waited = 1;
    @(negedge forever_cpuclk);
    while (!wb_vld && waited < WB_WAIT_MAX) begin
      if (is_div) begin
        confirm(ex1_stall, $sformatf("%s: ex1_stall low while divide runs", name));
      end
      @(negedge forever_cpuclk);
      waited++;
    end
    confirm(wb_vld, $sformatf("%s: no writeback within %0d cycles", name, WB_WAIT_MAX));
    confirm(!ex1_stall, $sformatf("%s: ex1_stall high at writeback", name));
  endtask

  task automatic apply_entry(input int idx);
    string    name;
    iu_func_e fn;
    int       waited;
    name = vec_name[idx];
    fn   = vec_fn[idx];
    drive_op(fn, vec_src0[idx], vec_src1[idx], vec_dst[idx]);
    @(negedge forever_cpuclk);
    if (fn <= FN_SLTU) begin
      confirm(ex1_fwd_vld, $sformatf("%s: ex1_fwd_vld low for ALU op", name));
      compare_word($sformatf("%s fwd", name), vec_exp[idx], ex1_fwd_data);
      compare_word($sformatf("%s fwd_preg", name), data_t'(vec_dst[idx]),
                   data_t'(ex1_fwd_preg));
    end else begin
      confirm(!ex1_fwd_vld, $sformatf("%s: ex1_fwd_vld high for non-ALU op", name));
    end
    @(posedge forever_cpuclk);
    #2;
    idle_ex1();
    await_wb(name, fn >= FN_DIV, waited);
    if (fn < FN_DIV) begin
      confirm(waited == 1, $sformatf("%s: writeback %0d cycles after issue", name, waited));
    end
    match_wb(name, vec_exp[idx], vec_dst[idx]);
    @(negedge forever_cpuclk);
    confirm(!wb_vld, $sformatf("%s: more than one writeback", name));
    @(posedge forever_cpuclk);
    #2;
  endtask

  // Back-to-back ALU and multiply ops that each retire one cycle after issue
  task automatic random_stream();
    iu_func_e fn;
    data_t    a;
    data_t    b;
    preg_t    dst;
    data_t    exp;
    string    name;
    string    prev_name;
    data_t    prev_exp;
    preg_t    prev_dst;
    logic     have_prev;
    have_prev = 1'b0;
    prev_name = "";
    prev_exp  = '0;
    prev_dst  = '0;
    for (int i = 0; i < STREAM_LEN; i++) begin
      fn   = iu_func_e'(5'($urandom_range(12, 0)));
      a    = $urandom;
      b    = $urandom;
      dst  = preg_t'($urandom_range(63, 0));
      exp  = predict(fn, a, b);
      name = $sformatf("stream%0d", i);
      drive_op(fn, a, b, dst);
      @(negedge forever_cpuclk);
      if (fn <= FN_SLTU) begin
        compare_word($sformatf("%s fwd", name), exp, ex1_fwd_data);
      end
      if (have_prev) begin
        match_wb(prev_name, prev_exp, prev_dst);
      end else begin
        confirm(!wb_vld, "wb_vld high before the stream started");
      end
      prev_name = name;
      prev_exp  = exp;
      prev_dst  = dst;
      have_prev = 1'b1;
      @(posedge forever_cpuclk);
      #2;
    end
    idle_ex1();
    @(negedge forever_cpuclk);
    match_wb(prev_name, prev_exp, prev_dst);
    @(posedge forever_cpuclk);
    #2;
  endtask

  task automatic flush_during_div();
    logic wb_seen;
    drive_op(FN_DIV, 32'd100, 32'd7, 6'd30);
    @(posedge forever_cpuclk);
    #2;
    idle_ex1();
    repeat (5) begin
      @(negedge forever_cpuclk);
      confirm(ex1_stall, "ex1_stall low while divide runs before flush");
    end
    @(posedge forever_cpuclk);
    #2;
    flush = 1'b1;
    @(posedge forever_cpuclk);
    #2;
    flush = 1'b0;
    @(negedge forever_cpuclk);
    confirm(!ex1_stall, "ex1_stall still high the cycle after flush");
    wb_seen = 1'b0;
    for (int i = 0; i < WB_WAIT_MAX; i++) begin
      wb_seen = wb_seen || wb_vld;
      @(negedge forever_cpuclk);
    end
    confirm(!wb_seen, "writeback appeared for a flushed divide");
    @(posedge forever_cpuclk);
    #2;
    drive_op(FN_SUB, 32'd100, 32'd58, 6'd31);
    @(negedge forever_cpuclk);
    compare_word("flush_sub fwd", 32'd42, ex1_fwd_data);
    @(posedge forever_cpuclk);
    #2;
    idle_ex1();
    @(negedge forever_cpuclk);
    match_wb("flush_sub", 32'd42, 6'd31);
    @(posedge forever_cpuclk);
    #2;
  endtask

  initial begin
    value_errs = 0;
    proto_errs = 0;
    void'($urandom(55629));
    load_table();
    cycle_limit = 10 + vec_fn.size() * (WB_WAIT_MAX + 4) + STREAM_LEN + 3 * WB_WAIT_MAX;
    rst   = 1'b1;
    flush = 1'b0;
    idle_ex1();
    repeat (2) @(posedge forever_cpuclk);
    #2;
    rst = 1'b0;
    @(negedge forever_cpuclk);
    confirm(!wb_vld && !ex1_stall, "wb_vld or ex1_stall high after reset");
    @(posedge forever_cpuclk);
    #2;
    foreach (vec_fn[i]) begin
      apply_entry(i);
    end
    random_stream();
    flush_during_div();
    $display("value errors: %0d, other errors: %0d", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* iu.f */
+incdir+sim
hw/iu_pkg.sv
hw/iu_ex1_if.sv
hw/iu_alu.sv
hw/iu_mul.sv
hw/iu_div.sv
hw/iu_ctrl.sv
hw/iu_top.sv
sim/iu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the integer unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f iu.f --top-module iu_tb -o iu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/iu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
